/* flist.f */
+incdir+testbench
common/audio_pkg.sv
design/mix_config_regs.sv
audio/sample_mixer.sv
audio/dynamic_compressor.sv
design/activity_led.sv
design/audio_top.sv
testbench/tb_audio_top.sv

/* testbench/audio_model.svh */
// Reference models for the clamped mix, both compression curves and LED on-time
`ifndef AUDIO_MODEL_SVH
`define AUDIO_MODEL_SVH

////////////////////////////////////////
// Mixer model
////////////////////////////////////////

// Sum of the three sources, wrapped to the 17-bit path, then saturated
function automatic logic [15:0] mix_model(
	input int sb,
	input int synth,
	input bit spk,
	input int vol,
	input bit mute
);
	int sum;
	int wrapped;
	sum = sb;
	if (!mute)
		sum = sum + synth;
	if (spk)
		sum = sum + (1 << (SPK_BASE_SHIFT + vol));
	wrapped = sum & 32'h1ffff;
	if (wrapped >= 65536)
		wrapped = wrapped - 131072;
	if (wrapped > 32767)
		return 16'h7fff;
	else if (wrapped < -32768)
		return 16'h8000;
	return wrapped[15:0];
endfunction

////////////////////////////////////////
// Compression model
////////////////////////////////////////

function automatic logic [15:0] curve_model(
	input logic [15:0] x,
	input int knee,
	input int gain,
	input int div,
	input int base
);
	int v;
	int mag;
	int res;
	v = $signed(x);
	mag = (v < 0) ? -v : v;
	if (mag < knee)
		res = mag * gain;
	else
		res = (mag - knee) / div + base;
	// Mirror the curve for negative samples
	if (v < 0)
		res = -res;
	return res[15:0];
endfunction

// Bypass for code 0, codes 2 and 3 share the 4x curve
function automatic logic [15:0] boost_model(input logic [15:0] mix, input logic [1:0] code);
	if (code == 2'd0)
		return mix;
	else if (code == 2'd1)
		return curve_model(mix, CMP2_KNEE, CMP2_GAIN, CMP2_DIV, CMP2_BASE);
	return curve_model(mix, CMP4_KNEE, CMP4_GAIN, CMP4_DIV, CMP4_BASE);
endfunction

// Edges counted from the edge that saw the request
function automatic bit led_model(input int edges_since_request);
	return edges_since_request < int'(LED_HOLD_CYCLES);
endfunction

`endif

/* testbench/tb_audio_top.sv */
// Testbench for the audio output stage with LFSR stimulus and model checks
`timescale 1ns/100ps
`default_nettype none

module tb_audio_top import audio_pkg::*; ();

	logic                        clk_sys;
	logic                        reset;
	logic                        cfg_req;
	logic [CFG_ADDR_W-1:0]       cfg_addr;
	logic [CFG_DATA_W-1:0]       cfg_data;
	logic                        cfg_ack;
	logic signed [SAMPLE_W-1:0]  sb_l;
	logic signed [SAMPLE_W-1:0]  sb_r;
	logic signed [SAMPLE_W-1:0]  synth_l;
	logic signed [SAMPLE_W-1:0]  synth_r;
	logic                        speaker;
	logic                        hdd_request;
	logic                        fdd_request;
	logic signed [SAMPLE_W-1:0]  audio_l;
	logic signed [SAMPLE_W-1:0]  audio_r;
	logic [1:0]                  audio_mix;
	logic                        led_hdd;
	logic                        led_fdd;

	// Register contents as the host expects them
	logic [1:0]  exp_vol;
	logic [1:0]  exp_boost;
	logic        exp_mute;
	logic [1:0]  exp_mix;

	logic [31:0] lfsr_state;
	int          mismatch_count;
	int          failure_count;

	`include "audio_model.svh"

	audio_top uut (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cfg_req     (cfg_req),
		.cfg_addr    (cfg_addr),
		.cfg_data    (cfg_data),
		.cfg_ack     (cfg_ack),
		.sb_l        (sb_l),
		.sb_r        (sb_r),
		.synth_l     (synth_l),
		.synth_r     (synth_r),
		.speaker     (speaker),
		.hdd_request (hdd_request),
		.fdd_request (fdd_request),
		.audio_l     (audio_l),
		.audio_r     (audio_r),
		.audio_mix   (audio_mix),
		.led_hdd     (led_hdd),
		.led_fdd     (led_fdd)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic bit next_bit();
		bit fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], next_bit()};
		return v;
	endfunction

	// One in four samples is full scale to force clamping
	function automatic logic [15:0] random_sample();
		logic [31:0] r;
		r = take_bits(2);
		if (r == 0)
			return take_bits(1) ? 16'h7fff : 16'h8000;
		r = take_bits(16);
		return r[15:0];
	endfunction

	task automatic step_clock();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic drive_sources();
		sb_l = random_sample();
		sb_r = random_sample();
		synth_l = random_sample();
		synth_r = random_sample();
		speaker = next_bit();
	endtask

	task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
		int wait_cnt;
		wait_cnt = 0;
		while (cfg_ack && wait_cnt < 8) begin
			step_clock();
			wait_cnt++;
		end
		if (cfg_ack) begin
			failure_count++;
			$display("Write to register %0d: cfg_ack still high before the request", addr);
		end
		cfg_req = 1'b1;
		cfg_addr = addr;
		cfg_data = data;
		wait_cnt = 0;
		do begin
			step_clock();
			wait_cnt++;
		end while (!cfg_ack && wait_cnt < 8);
		if (!cfg_ack) begin
			failure_count++;
			$display("Write to register %0d: cfg_ack never rose", addr);
		end
		cfg_req = 1'b0;
		wait_cnt = 0;
		do begin
			step_clock();
			wait_cnt++;
		end while (cfg_ack && wait_cnt < 8);
		if (cfg_ack) begin
			failure_count++;
			$display("Write to register %0d: cfg_ack did not fall after cfg_req dropped", addr);
		end
		case (addr)
			2'd0: exp_vol = data[1:0];
			2'd1: exp_boost = data[1:0];
			2'd2: exp_mute = data[0];
			default: exp_mix = data[1:0];
		endcase
	endtask

	// Hold the sources long enough for either latency, then compare both sides
	task automatic hold_and_check(input string name);
		logic [15:0] exp_l;
		logic [15:0] exp_r;
		repeat (6) step_clock();
		exp_l = boost_model(mix_model(sb_l, synth_l, speaker, exp_vol, exp_mute), exp_boost);
		exp_r = boost_model(mix_model(sb_r, synth_r, speaker, exp_vol, exp_mute), exp_boost);
		if (audio_l !== exp_l) begin
			mismatch_count++;
			$display("Mismatch %s left: expected %h, actual %h", name, exp_l, audio_l);
		end
		if (audio_r !== exp_r) begin
			mismatch_count++;
			$display("Mismatch %s right: expected %h, actual %h", name, exp_r, audio_r);
		end
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		int n;
		int limit;
		lfsr_state = 32'hc55b;
		mismatch_count = 0;
		failure_count = 0;
		exp_vol = 2'd0;
		exp_boost = 2'd0;
		exp_mute = 1'b0;
		exp_mix = 2'd0;
		reset = 1'b1;
		cfg_req = 1'b0;
		cfg_addr = '0;
		cfg_data = '0;
		hdd_request = 1'b0;
		fdd_request = 1'b0;
		drive_sources();
		repeat (10) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		// Reset state, pipeline already filled from the held inputs
		if (cfg_ack !== 1'b0 || led_hdd !== 1'b0 || led_fdd !== 1'b0) begin
			mismatch_count++;
			$display("Mismatch reset_state: expected ack/hdd/fdd 000, actual %b%b%b",
				cfg_ack, led_hdd, led_fdd);
		end
		if (audio_mix !== 2'd0) begin
			mismatch_count++;
			$display("Mismatch reset_mix: expected 0, actual %h", audio_mix);
		end
		hold_and_check("reset_bypass");

		// Handshake, every address gets random data
		for (int i = 0; i < 16; i++) begin
			write_reg(i[1:0], 8'(take_bits(8)));
			if (audio_mix !== exp_mix) begin
				mismatch_count++;
				$display("Mismatch handshake_mix: expected %h, actual %h", exp_mix, audio_mix);
			end
		end
		write_reg(REG_BOOST, 8'd0);

		// Bypass mix with occasional volume and mute changes
		for (int i = 0; i < 48; i++) begin
			if (take_bits(2) == 0) begin
				write_reg(REG_SPK_VOL, 8'(take_bits(2)));
				write_reg(REG_SYNTH_MUTE, 8'(take_bits(1)));
			end
			drive_sources();
			hold_and_check("bypass");
		end

		for (int code = 1; code < 4; code++) begin
			write_reg(REG_BOOST, 8'(code));
			for (int i = 0; i < 24; i++) begin
				drive_sources();
				hold_and_check($sformatf("compress_%0d", code));
			end
		end

		// Single hard disk pulse
		hdd_request = 1'b1;
		step_clock();
		hdd_request = 1'b0;
		n = 0;
		while (!led_hdd && n < 2) begin
			step_clock();
			n++;
		end
		if (!led_hdd) begin
			failure_count++;
			$display("led_hdd did not turn on within 2 cycles of a request");
		end
		while (n < int'(LED_HOLD_CYCLES) - 5) begin
			step_clock();
			n++;
		end
		if (led_hdd !== led_model(n) || led_fdd !== 1'b0) begin
			mismatch_count++;
			$display("Mismatch led_hdd_hold: expected 1, actual %b (fdd %b)", led_hdd, led_fdd);
		end
		while (n < int'(LED_HOLD_CYCLES) + 5) begin
			step_clock();
			n++;
		end
		if (led_hdd !== led_model(n)) begin
			mismatch_count++;
			$display("Mismatch led_hdd_off: expected 0, actual %b", led_hdd);
		end

		// Repeated floppy pulses, the last one left to expire
		for (int p = 0; p < 4; p++) begin
			fdd_request = 1'b1;
			step_clock();
			fdd_request = 1'b0;
			n = 0;
			limit = (p == 3) ? int'(LED_HOLD_CYCLES) + 5 : 200 + int'(take_bits(8));
			while (n <= limit) begin
				if (led_fdd !== led_model(n) || led_hdd !== 1'b0) begin
					mismatch_count++;
					$display("Mismatch led_fdd: expected %b, actual %b", led_model(n), led_fdd);
				end
				if (n < limit)
					step_clock();
				n++;
			end
		end

		$display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* design/audio_top.sv */
// Audio output stage top with settings registers, mixer, compressor and disk LEDs
`timescale 1ns/100ps
`default_nettype none

module audio_top import audio_pkg::*; (
	input  wire                        clk_sys,
	input  wire                        reset,

	// Host register port
	input  wire                        cfg_req,
	input  wire [CFG_ADDR_W-1:0]       cfg_addr,
	input  wire [CFG_DATA_W-1:0]       cfg_data,
	output logic                       cfg_ack,

	// Sources
	input  wire signed [SAMPLE_W-1:0]  sb_l,
	input  wire signed [SAMPLE_W-1:0]  sb_r,
	input  wire signed [SAMPLE_W-1:0]  synth_l,
	input  wire signed [SAMPLE_W-1:0]  synth_r,
	input  wire                        speaker,

	// Disk activity
	input  wire                        hdd_request,
	input  wire                        fdd_request,

	output logic signed [SAMPLE_W-1:0] audio_l,
	output logic signed [SAMPLE_W-1:0] audio_r,
	output logic [1:0]                 audio_mix,
	output logic                       led_hdd,
	output logic                       led_fdd
);

	logic [VOL_W-1:0]           spk_vol;
	boost_mode_e                boost;
	logic                       synth_mute;
	logic signed [SAMPLE_W-1:0] mix_l;
	logic signed [SAMPLE_W-1:0] mix_r;

	////////////////////////////////////////
	// Settings
	////////////////////////////////////////

	mix_config_regs cfg_regs (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cfg_req    (cfg_req),
		.cfg_addr   (cfg_addr),
		.cfg_data   (cfg_data),
		.cfg_ack    (cfg_ack),
		.spk_vol    (spk_vol),
		.boost      (boost),
		.synth_mute (synth_mute),
		.stereo_mix (audio_mix)
	);

	////////////////////////////////////////
	// Audio path
	////////////////////////////////////////

	sample_mixer mixer (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.sb_l       (sb_l),
		.sb_r       (sb_r),
		.synth_l    (synth_l),
		.synth_r    (synth_r),
		.speaker    (speaker),
		.spk_vol    (spk_vol),
		.synth_mute (synth_mute),
		.mix_l      (mix_l),
		.mix_r      (mix_r)
	);

	dynamic_compressor compressor (
		.clk_sys (clk_sys),
		.reset   (reset),
		.mix_l   (mix_l),
		.mix_r   (mix_r),
		.boost   (boost),
		.audio_l (audio_l),
		.audio_r (audio_r)
	);

	////////////////////////////////////////
	// Disk LEDs
	////////////////////////////////////////

	activity_led hdd_led (
		.clk_sys (clk_sys),
		.reset   (reset),
		.request (hdd_request),
		.led     (led_hdd)
	);

	activity_led fdd_led (
		.clk_sys (clk_sys),
		.reset   (reset),
		.request (fdd_request),
		.led     (led_fdd)
	);

endmodule

`default_nettype wire

/* design/activity_led.sv */
// Pulse stretcher that keeps a disk activity LED lit after each request
`timescale 1ns/100ps
`default_nettype none

module activity_led import audio_pkg::*; (
	input  wire  clk_sys,
	input  wire  reset,
	input  wire  request,
	output logic led
);

	logic [31:0] hold_cnt;

	// Every request restarts the full on-time
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hold_cnt <= '0;
		end else if (request) begin
			hold_cnt <= LED_HOLD_CYCLES;
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 32'd1;
		end
	end

	// Lit while time remains
	assign led = (hold_cnt != '0);

endmodule

`default_nettype wire

/* audio/dynamic_compressor.sv */
// Sign-symmetric 2x and 4x compression curves with boost-driven output select
`timescale 1ns/100ps
`default_nettype none

module dynamic_compressor import audio_pkg::*; (
	input  wire                        clk_sys,
	input  wire                        reset,

	input  wire signed [SAMPLE_W-1:0]  mix_l,
	input  wire signed [SAMPLE_W-1:0]  mix_r,
	input  boost_mode_e                boost,

	output logic signed [SAMPLE_W-1:0] audio_l,
	output logic signed [SAMPLE_W-1:0] audio_r
);

	logic [SAMPLE_W-1:0] cmp2_l;
	logic [SAMPLE_W-1:0] cmp2_r;
	logic [SAMPLE_W-1:0] cmp4_l;
	logic [SAMPLE_W-1:0] cmp4_r;

	// Linear below the knee, divided slope above it, all in 16 bits
	function automatic logic [15:0] compress(
		input logic [15:0] x,
		input logic [15:0] knee,
		input logic [15:0] gain,
		input logic [15:0] div,
		input logic [15:0] base
	);
		logic [15:0] mag;
		logic [15:0] res;
		mag = x[15] ? (~x + 16'd1) : x;
		if (mag < knee)
			res = mag * gain;
		else
			res = ((mag - knee) / div) + base;
		return x[15] ? (~res + 16'd1) : res;
	endfunction

	////////////////////////////////////////
	// Curve registers
	////////////////////////////////////////

	// Both curves run all the time so a boost change takes effect at once
	always_ff @(posedge clk_sys) begin
		cmp2_l <= compress(mix_l, CMP2_KNEE, CMP2_GAIN, CMP2_DIV, CMP2_BASE);
		cmp2_r <= compress(mix_r, CMP2_KNEE, CMP2_GAIN, CMP2_DIV, CMP2_BASE);
		cmp4_l <= compress(mix_l, CMP4_KNEE, CMP4_GAIN, CMP4_DIV, CMP4_BASE);
		cmp4_r <= compress(mix_r, CMP4_KNEE, CMP4_GAIN, CMP4_DIV, CMP4_BASE);
	end

	////////////////////////////////////////
	// Output select
	////////////////////////////////////////

	always_comb begin
		case (boost)
			BOOST_NONE: begin
				audio_l = mix_l;
				audio_r = mix_r;
			end
			BOOST_2X: begin
				audio_l = cmp2_l;
				audio_r = cmp2_r;
			end
			BOOST_4X, BOOST_4X_ALT: begin
				audio_l = cmp4_l;
				audio_r = cmp4_r;
			end
			default: begin
				audio_l = mix_l;
				audio_r = mix_r;
			end
		endcase
	end

	// Curves keep the sign and never collapse a nonzero sample to silence
	keep_sign_l: assert property (
		@(posedge clk_sys) disable iff (reset)
		(mix_l != 0) |=> (cmp4_l[15] == $past(mix_l[15])) && (cmp4_l != 0)
			&& (cmp2_l[15] == $past(mix_l[15])) && (cmp2_l != 0)
	) else $error("left compression flipped sign");

	keep_sign_r: assert property (
		@(posedge clk_sys) disable iff (reset)
		(mix_r != 0) |=> (cmp4_r[15] == $past(mix_r[15])) && (cmp4_r != 0)
			&& (cmp2_r[15] == $past(mix_r[15])) && (cmp2_r != 0)
	) else $error("right compression flipped sign");

endmodule

`default_nettype wire

/* audio/sample_mixer.sv */
// Two-stage mixer for sound card, synth and speaker with 16-bit saturation
`timescale 1ns/100ps
`default_nettype none

module sample_mixer import audio_pkg::*; (
	input  wire                        clk_sys,
	input  wire                        reset,

	// Sources
	input  wire signed [SAMPLE_W-1:0]  sb_l,
	input  wire signed [SAMPLE_W-1:0]  sb_r,
	input  wire signed [SAMPLE_W-1:0]  synth_l,
	input  wire signed [SAMPLE_W-1:0]  synth_r,
	input  wire                        speaker,

	// Settings
	input  wire        [VOL_W-1:0]     spk_vol,
	input  wire                        synth_mute,

	// Clamped mix
	output logic signed [SAMPLE_W-1:0] mix_l,
	output logic signed [SAMPLE_W-1:0] mix_r
);

	logic [SUM_W-1:0] spk_term;
	logic [SUM_W-1:0] sb_ext_l;
	logic [SUM_W-1:0] sb_ext_r;
	logic [SUM_W-1:0] synth_term_l;
	logic [SUM_W-1:0] synth_term_r;
	logic [SUM_W-1:0] sum_l;
	logic [SUM_W-1:0] sum_r;

	// Saturate when the guard bit disagrees with the sample sign bit
	function automatic logic [SAMPLE_W-1:0] clamp(input logic [SUM_W-1:0] s);
		logic ovf;
		ovf = s[SUM_W-1] ^ s[SUM_W-2];
		if (!ovf)
			return s[SAMPLE_W-1:0];
		else if (s[SUM_W-1])
			return 16'h8000;
		else
			return 16'h7fff;
	endfunction

	////////////////////////////////////////
	// Stage 1, source terms and sum
	////////////////////////////////////////

	// Speaker pulse is always positive, volume shifts it up
	assign spk_term = SUM_W'(speaker) << (SPK_BASE_SHIFT + spk_vol);

	assign sb_ext_l = {sb_l[SAMPLE_W-1], sb_l};
	assign sb_ext_r = {sb_r[SAMPLE_W-1], sb_r};

	assign synth_term_l = synth_mute ? '0 : {synth_l[SAMPLE_W-1], synth_l};
	assign synth_term_r = synth_mute ? '0 : {synth_r[SAMPLE_W-1], synth_r};

	always_ff @(posedge clk_sys) begin
		sum_l <= sb_ext_l + synth_term_l + spk_term;
		sum_r <= sb_ext_r + synth_term_r + spk_term;
	end

	////////////////////////////////////////
	// Stage 2, clamp to a sample
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		mix_l <= clamp(sum_l);
		mix_r <= clamp(sum_r);
	end

	// An overflowing sum must never pass its low bits through
	sat_left: assert property (
		@(posedge clk_sys) disable iff (reset)
		(sum_l[SUM_W-1] != sum_l[SUM_W-2]) |=> (mix_l != $past(sum_l[SAMPLE_W-1:0]))
	) else $error("left mix not saturated on overflow");

	sat_right: assert property (
		@(posedge clk_sys) disable iff (reset)
		(sum_r[SUM_W-1] != sum_r[SUM_W-2]) |=> (mix_r != $past(sum_r[SAMPLE_W-1:0]))
	) else $error("right mix not saturated on overflow");

endmodule

`default_nettype wire

/* design/mix_config_regs.sv */
// Host settings registers for the audio stage with a four-phase req/ack write port
`timescale 1ns/100ps
`default_nettype none

module mix_config_regs import audio_pkg::*; (
	input  wire                  clk_sys,
	input  wire                  reset,

	// Host write port
	input  wire                  cfg_req,
	input  wire [CFG_ADDR_W-1:0] cfg_addr,
	input  wire [CFG_DATA_W-1:0] cfg_data,
	output logic                 cfg_ack,

	// Settings
	output logic [VOL_W-1:0]     spk_vol,
	output boost_mode_e          boost,
	output logic                 synth_mute,
	output logic [1:0]           stereo_mix
);

	cfg_reg_e  reg_sel;
	logic      wr_en;

	assign reg_sel = cfg_reg_e'(cfg_addr);

	// A new request is accepted only while ack is low
	assign wr_en = cfg_req && !cfg_ack;

	////////////////////////////////////////
	// Handshake
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cfg_ack <= 1'b0;
		end else if (wr_en) begin
			cfg_ack <= 1'b1;
		end else if (!cfg_req) begin
			cfg_ack <= 1'b0;
		end
	end

	////////////////////////////////////////
	// Settings
	////////////////////////////////////////

	// Upper data bits beyond each field are dropped
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			spk_vol    <= '0;
			boost      <= BOOST_NONE;
			synth_mute <= 1'b0;
			stereo_mix <= 2'b00;
		end else if (wr_en) begin
			case (reg_sel)
				REG_SPK_VOL: begin
					spk_vol <= cfg_data[VOL_W-1:0];
				end
				REG_BOOST: begin
					boost <= boost_mode_e'(cfg_data[1:0]);
				end
				REG_SYNTH_MUTE: begin
					synth_mute <= cfg_data[0];
				end
				REG_STEREO_MIX: begin
					stereo_mix <= cfg_data[1:0];
				end
				default: begin
					stereo_mix <= stereo_mix;
				end
			endcase
		end
	end

	////////////////////////////////////////
	// Protocol checks
	////////////////////////////////////////

	// Ack only answers a request seen on the previous edge
	ack_needs_req: assert property (
		@(posedge clk_sys) disable iff (reset)
		$rose(cfg_ack) |-> $past(cfg_req)
	) else $error("cfg_ack rose without cfg_req");

	// Ack drops on the first edge after the request is withdrawn
	ack_release: assert property (
		@(posedge clk_sys) disable iff (reset)
		(cfg_ack && !cfg_req) |=> !cfg_ack
	) else $error("cfg_ack held after cfg_req fell");

endmodule

`default_nettype wire

/* common/audio_pkg.sv */
// Audio widths, compression curve constants, register map and mode enums
`default_nettype none

package audio_pkg;

	////////////////////////////////////////
	// Sample path widths
	////////////////////////////////////////

	// Signed audio sample
	localparam int SAMPLE_W = 16;

	// Summing path, one guard bit above a sample
	localparam int SUM_W = 17;

	// Speaker pulse lands at bit 11 for volume 0
	localparam int SPK_BASE_SHIFT = 11;

	// Speaker volume code, each step doubles the pulse
	localparam int VOL_W = 2;

	////////////////////////////////////////
	// Compression curves
	////////////////////////////////////////

	// 2x curve, linear gain below the knee
	localparam logic [15:0] CMP2_KNEE = 16'd14043;
	localparam logic [15:0] CMP2_GAIN = 16'd2;
	localparam logic [15:0] CMP2_DIV  = 16'd4;
	// Knee times gain, where the upper segment starts
	localparam logic [15:0] CMP2_BASE = 16'd28086;

	// 4x curve, steeper gain and flatter top
	localparam logic [15:0] CMP4_KNEE = 16'd7399;
	localparam logic [15:0] CMP4_GAIN = 16'd4;
	localparam logic [15:0] CMP4_DIV  = 16'd8;
	localparam logic [15:0] CMP4_BASE = 16'd29596;

	////////////////////////////////////////
	// Activity LEDs
	////////////////////////////////////////

	// On-time after the last disk request
	localparam logic [31:0] LED_HOLD_CYCLES = 32'd1000;

	////////////////////////////////////////
	// Register port
	////////////////////////////////////////

	localparam int CFG_ADDR_W = 2;
	localparam int CFG_DATA_W = 8;

	typedef enum logic [CFG_ADDR_W-1:0] {
		REG_SPK_VOL    = 2'd0,
		REG_BOOST      = 2'd1,
		REG_SYNTH_MUTE = 2'd2,
		REG_STEREO_MIX = 2'd3
	} cfg_reg_e;

	// Code 3 is an alias of the 4x curve
	typedef enum logic [1:0] {
		BOOST_NONE   = 2'd0,
		BOOST_2X     = 2'd1,
		BOOST_4X     = 2'd2,
		BOOST_4X_ALT = 2'd3
	} boost_mode_e;

endpackage

`default_nettype wire
